// File: hdl/rd_demux_pkg.sv
// shared bus field types for the read demux
// ids are 4 bits wide, and at most 4 target ports can be named by a select
package rd_demux_pkg;

  // --------------------------------------------------------------------------
  // field widths
  // --------------------------------------------------------------------------
  // port number width, so 4 target ports at most
  localparam int unsigned SelWidth = 2;
  // transaction id width
  localparam int unsigned IdWidth = 4;

  // names one target port
  typedef logic [SelWidth-1:0] sel_t;
  // transaction id, the low bits pick an in-flight counter
  typedef logic [IdWidth-1:0] id_t;
  // read address
  typedef logic [15:0] addr_t;
  // one read data word
  typedef logic [15:0] data_t;
  // burst length minus one
  typedef logic [3:0] len_t;

  // --------------------------------------------------------------------------
  // channel beats
  // --------------------------------------------------------------------------
  // one read request, 24 bits
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
  } ar_beat_t;

  // one read data beat, 21 bits
  typedef struct packed {
    id_t   id;
    data_t data;
    logic  last;
  } r_beat_t;

endpackage

// File: hdl/rd_id_tracker.sv
// in-flight counters indexed by the low LookBits bits of the id
// LookBits must not exceed the id width; a counter never wraps as full stalls pushes
`timescale 1ns/1ns

module rd_id_tracker #(
  parameter int unsigned LookBits = 2,
  parameter int unsigned CntWidth = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // lookup
  input  rd_demux_pkg::id_t  lookup_id_i,
  output rd_demux_pkg::sel_t lookup_sel_o,
  output logic               occupied_o,
  output logic               full_o,
  // push on each request transfer
  input  logic               push_i,
  input  rd_demux_pkg::id_t  push_id_i,
  input  rd_demux_pkg::sel_t push_sel_i,
  // pop on each last data beat
  input  logic               pop_i,
  input  rd_demux_pkg::id_t  pop_id_i
);

  localparam int unsigned NumCnt = 2**LookBits;

  typedef logic [CntWidth-1:0] cnt_t;
  typedef logic [LookBits-1:0] idx_t;

  cnt_t               cnt_q [NumCnt];
  rd_demux_pkg::sel_t sel_q [NumCnt];
  logic [NumCnt-1:0]  cnt_full;
  idx_t               lookup_idx;
  idx_t               push_idx;
  idx_t               pop_idx;

  // only the low id bits matter
  assign lookup_idx = lookup_id_i[LookBits-1:0];
  assign push_idx   = push_id_i[LookBits-1:0];
  assign pop_idx    = pop_id_i[LookBits-1:0];

  // --------------------------------------------------------------------------
  // lookup
  // --------------------------------------------------------------------------
  assign lookup_sel_o = sel_q[lookup_idx];
  assign occupied_o   = |cnt_q[lookup_idx];
  // any saturated counter blocks every new request
  assign full_o       = |cnt_full;

  // --------------------------------------------------------------------------
  // counters
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NumCnt; i++) begin : gen_cnt
    logic push_hit;
    logic pop_hit;

    assign push_hit    = push_i && (push_idx == idx_t'(i));
    assign pop_hit     = pop_i && (pop_idx == idx_t'(i));
    assign cnt_full[i] = &cnt_q[i];

    // push and pop together leave the count as it is
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        cnt_q[i] <= '0;
      end else if (push_hit && !pop_hit) begin
        cnt_q[i] <= cnt_q[i] + cnt_t'(1);
      end else if (pop_hit && !push_hit) begin
        cnt_q[i] <= cnt_q[i] - cnt_t'(1);
      end
    end

    // port of the latest push, only meaningful while the count is non-zero
    always_ff @(posedge clk_i) begin
      if (push_hit) begin
        sel_q[i] <= push_sel_i;
      end
    end
  end

endmodule

// File: hdl/ar_router.sv
// steers read requests to one target port, combinational in both directions
// a select at or above NumPorts is never served, the request then waits forever
`timescale 1ns/1ns

module ar_router #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // requester side
  input  rd_demux_pkg::ar_beat_t   ar_i,
  input  rd_demux_pkg::sel_t       ar_sel_i,
  input  logic                     ar_valid_i,
  output logic                     ar_ready_o,
  // target side
  output rd_demux_pkg::ar_beat_t   port_ar_o,
  output logic [NumPorts-1:0]      port_ar_valid_o,
  input  logic [NumPorts-1:0]      port_ar_ready_i,
  // id tracker
  output rd_demux_pkg::id_t        lookup_id_o,
  input  rd_demux_pkg::sel_t       lookup_sel_i,
  input  logic                     occupied_i,
  input  logic                     full_i,
  output logic                     push_o,
  output rd_demux_pkg::id_t        push_id_o,
  output rd_demux_pkg::sel_t       push_sel_o
);

  // locked holds the port valid after an offer without ready
  typedef enum logic {
    idle,
    locked
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   may_pass;
  logic   offer;
  logic   sel_ready;

  // --------------------------------------------------------------------------
  // ordering check
  // --------------------------------------------------------------------------
  assign lookup_id_o = ar_i.id;
  // same id may only follow to the port it already went to
  assign may_pass = !full_i && (!occupied_i || (lookup_sel_i == ar_sel_i));
  // once offered, the valid stays up whatever the tracker says
  assign offer = (state_q == locked) || (ar_valid_i && may_pass);

  // --------------------------------------------------------------------------
  // steering
  // --------------------------------------------------------------------------
  assign port_ar_o = ar_i;

  always_comb begin
    port_ar_valid_o = '0;
    sel_ready       = 1'b0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      if (ar_sel_i == rd_demux_pkg::sel_t'(i)) begin
        port_ar_valid_o[i] = offer;
        sel_ready          = port_ar_ready_i[i];
      end
    end
  end

  assign ar_ready_o = offer && sel_ready;

  // tracker records every completed request
  assign push_o     = ar_valid_i && ar_ready_o;
  assign push_id_o  = ar_i.id;
  assign push_sel_o = ar_sel_i;

  // --------------------------------------------------------------------------
  // valid lock
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        // offered but the target is not ready yet
        if (offer && !sel_ready) begin
          state_d = locked;
        end
      end
      locked: begin
        if (sel_ready) begin
          state_d = idle;
        end
      end
      default: state_d = idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// File: hdl/r_arbiter.sv
// round-robin merge of read data bursts, bursts never interleave
// the grant is held from the first offered beat until the last beat transfers
`timescale 1ns/1ns

module r_arbiter #(
  parameter int unsigned NumPorts = 3
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // target side
  input  rd_demux_pkg::r_beat_t [NumPorts-1:0] port_r_i,
  input  logic [NumPorts-1:0]                  port_r_valid_i,
  output logic [NumPorts-1:0]                  port_r_ready_o,
  // requester side
  output rd_demux_pkg::r_beat_t                r_o,
  output logic                                 r_valid_o,
  input  logic                                 r_ready_i,
  // id tracker
  output logic                                 pop_o,
  output rd_demux_pkg::id_t                    pop_id_o
);

  rd_demux_pkg::sel_t prio_q;
  rd_demux_pkg::sel_t gnt_idx_q;
  rd_demux_pkg::sel_t sel_idx;
  logic               lock_q;
  logic               found;
  logic               last_xfer;

  // --------------------------------------------------------------------------
  // grant selection
  // --------------------------------------------------------------------------
  always_comb begin
    int unsigned cand;
    sel_idx = gnt_idx_q;
    found   = 1'b0;
    cand    = 0;
    // search starts one past the previous winner
    if (!lock_q) begin
      for (int unsigned off = 1; off <= NumPorts; off++) begin
        cand = (int'(prio_q) + off) % NumPorts;
        if (!found && port_r_valid_i[cand]) begin
          found   = 1'b1;
          sel_idx = rd_demux_pkg::sel_t'(cand);
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // data path and handshake
  // --------------------------------------------------------------------------
  assign r_o       = port_r_i[sel_idx];
  assign r_valid_o = port_r_valid_i[sel_idx];

  // back-pressure only reaches the granted port
  always_comb begin
    port_r_ready_o          = '0;
    port_r_ready_o[sel_idx] = r_valid_o && r_ready_i;
  end

  assign last_xfer = r_valid_o && r_ready_i && r_o.last;
  assign pop_o     = last_xfer;
  assign pop_id_o  = r_o.id;

  // --------------------------------------------------------------------------
  // grant lock and round-robin pointer
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q    <= 1'b0;
      gnt_idx_q <= '0;
      // port 0 has the first turn
      prio_q    <= rd_demux_pkg::sel_t'(NumPorts - 1);
    end else begin
      if (last_xfer) begin
        lock_q <= 1'b0;
        prio_q <= sel_idx;
      end else if (r_valid_o) begin
        lock_q <= 1'b1;
      end
      // freeze the winner on its first offered beat
      if (!lock_q && found) begin
        gnt_idx_q <= sel_idx;
      end
    end
  end

endmodule

// File: hdl/rd_demux_top.sv
// read half of a one-to-many demux, 0-cycle latency on request and data paths
// NumPorts 2 to 4; requests with one id stay on one port while in flight
`timescale 1ns/1ns

module rd_demux_top #(
  parameter int unsigned NumPorts = 3,
  parameter int unsigned LookBits = 2,
  parameter int unsigned CntWidth = 2
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  // requester read request
  input  rd_demux_pkg::ar_beat_t               ar_i,
  input  rd_demux_pkg::sel_t                   ar_sel_i,
  input  logic                                 ar_valid_i,
  output logic                                 ar_ready_o,
  // target read requests
  output rd_demux_pkg::ar_beat_t               port_ar_o,
  output logic [NumPorts-1:0]                  port_ar_valid_o,
  input  logic [NumPorts-1:0]                  port_ar_ready_i,
  // target read data
  input  rd_demux_pkg::r_beat_t [NumPorts-1:0] port_r_i,
  input  logic [NumPorts-1:0]                  port_r_valid_i,
  output logic [NumPorts-1:0]                  port_r_ready_o,
  // requester read data
  output rd_demux_pkg::r_beat_t                r_o,
  output logic                                 r_valid_o,
  input  logic                                 r_ready_i
);

  // tracker lookup
  rd_demux_pkg::id_t  lookup_id;
  rd_demux_pkg::sel_t lookup_sel;
  logic               occupied;
  logic               full;
  // tracker updates
  logic               push;
  rd_demux_pkg::id_t  push_id;
  rd_demux_pkg::sel_t push_sel;
  logic               pop;
  rd_demux_pkg::id_t  pop_id;

  ar_router #(
    .NumPorts(NumPorts)
  ) i_ar_router (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ar_i           (ar_i),
    .ar_sel_i       (ar_sel_i),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .port_ar_o      (port_ar_o),
    .port_ar_valid_o(port_ar_valid_o),
    .port_ar_ready_i(port_ar_ready_i),
    .lookup_id_o    (lookup_id),
    .lookup_sel_i   (lookup_sel),
    .occupied_i     (occupied),
    .full_i         (full),
    .push_o         (push),
    .push_id_o      (push_id),
    .push_sel_o     (push_sel)
  );

  rd_id_tracker #(
    .LookBits(LookBits),
    .CntWidth(CntWidth)
  ) i_rd_id_tracker (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .lookup_id_i (lookup_id),
    .lookup_sel_o(lookup_sel),
    .occupied_o  (occupied),
    .full_o      (full),
    .push_i      (push),
    .push_id_i   (push_id),
    .push_sel_i  (push_sel),
    .pop_i       (pop),
    .pop_id_i    (pop_id)
  );

  r_arbiter #(
    .NumPorts(NumPorts)
  ) i_r_arbiter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .port_r_i      (port_r_i),
    .port_r_valid_i(port_r_valid_i),
    .port_r_ready_o(port_r_ready_o),
    .r_o           (r_o),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .pop_o         (pop),
    .pop_id_o      (pop_id)
  );

endmodule

// File: sim/tb_rd_demux.sv
// testbench for the read demux with three target ports, random readies and in-order data
// stimulus comes from a fixed-seed 16-bit lfsr and ids 0 to 7 share tracker counters
`timescale 1ns/1ns

module tb_rd_demux;

  localparam int unsigned NumPorts  = 3;
  localparam int unsigned LookBits  = 2;
  localparam int unsigned CntWidth  = 2;
  localparam int unsigned NumReq    = 40;
  // reads per counter that make it full
  localparam int unsigned MaxFlight = 2**CntWidth - 1;

  typedef struct packed {
    rd_demux_pkg::sel_t     sel;
    rd_demux_pkg::ar_beat_t ar;
  } req_t;

  logic                                 clk_i;
  logic                                 rst_n_i;
  rd_demux_pkg::ar_beat_t               ar_i;
  rd_demux_pkg::sel_t                   ar_sel_i;
  logic                                 ar_valid_i;
  logic                                 ar_ready_o;
  rd_demux_pkg::ar_beat_t               port_ar_o;
  logic [NumPorts-1:0]                  port_ar_valid_o;
  logic [NumPorts-1:0]                  port_ar_ready_i;
  rd_demux_pkg::r_beat_t [NumPorts-1:0] port_r_i;
  logic [NumPorts-1:0]                  port_r_valid_i;
  logic [NumPorts-1:0]                  port_r_ready_o;
  rd_demux_pkg::r_beat_t                r_o;
  logic                                 r_valid_o;
  logic                                 r_ready_i;

  logic [15:0] lfsr_q;
  // requests still to send
  req_t        stim_q[$];
  // accepted reads whose last beat has not yet reached r_o
  req_t        issued_q[$];
  // reads the port models have yet to answer in full
  req_t        pend_q[$];
  int unsigned port_beat [NumPorts];
  logic        hold_r;
  logic        offer_pending;
  logic        burst_active;
  req_t        cur_req;
  int          cur_idx;
  int unsigned cur_beat;
  int unsigned cycle_cnt;
  int unsigned cycle_limit;

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  rd_demux_top #(
    .NumPorts(NumPorts),
    .LookBits(LookBits),
    .CntWidth(CntWidth)
  ) i_rd_demux_top (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ar_i           (ar_i),
    .ar_sel_i       (ar_sel_i),
    .ar_valid_i     (ar_valid_i),
    .ar_ready_o     (ar_ready_o),
    .port_ar_o      (port_ar_o),
    .port_ar_valid_o(port_ar_valid_o),
    .port_ar_ready_i(port_ar_ready_i),
    .port_r_i       (port_r_i),
    .port_r_valid_i (port_r_valid_i),
    .port_r_ready_o (port_r_ready_o),
    .r_o            (r_o),
    .r_valid_o      (r_valid_o),
    .r_ready_i      (r_ready_i)
  );

  // --------------------------------------------------------------------------
  // helpers and reference
  // --------------------------------------------------------------------------
  // fibonacci lfsr with taps 16 14 13 11 stepped once per bit
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  // data word a target returns with the port in bits 13:12 and the beat in each low nibble
  function automatic rd_demux_pkg::data_t expected_data(int unsigned port,
      rd_demux_pkg::addr_t addr, int unsigned beat);
    return addr ^ rd_demux_pkg::data_t'(port << 12) ^ rd_demux_pkg::data_t'(beat * 'h111);
  endfunction

  // reads in flight that share one tracker counter
  function automatic int unsigned count_flight(int unsigned idx);
    int unsigned n;
    n = 0;
    foreach (issued_q[i]) begin
      if (issued_q[i].ar.id[LookBits-1:0] == idx[LookBits-1:0]) n++;
    end
    return n;
  endfunction

  // a new request may go out only with no counter full and its own counter idle or on its port
  function automatic logic may_forward(rd_demux_pkg::id_t id, rd_demux_pkg::sel_t sel);
    logic ok;
    ok = 1'b1;
    for (int unsigned c = 0; c < 2**LookBits; c++) begin
      if (count_flight(c) >= MaxFlight) ok = 1'b0;
    end
    foreach (issued_q[i]) begin
      if (issued_q[i].ar.id[LookBits-1:0] == id[LookBits-1:0] && issued_q[i].sel != sel) begin
        ok = 1'b0;
      end
    end
    return ok;
  endfunction

  // oldest unanswered read of one port
  function automatic int find_port_head(int unsigned p);
    int idx;
    idx = -1;
    foreach (pend_q[i]) begin
      if (idx < 0 && pend_q[i].sel == rd_demux_pkg::sel_t'(p)) idx = i;
    end
    return idx;
  endfunction

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic build_stimulus();
    req_t r;
    for (int unsigned i = 0; i < NumReq; i++) begin
      r.ar.addr = rd_demux_pkg::addr_t'(rand_bits(16));
      r.ar.len  = rd_demux_pkg::len_t'(rand_bits(2));
      // narrow id range so ids clash often
      r.ar.id   = rd_demux_pkg::id_t'(rand_bits(3));
      r.sel     = rd_demux_pkg::sel_t'(rand_bits(2) % NumPorts);
      // the first three fill one counter and the fourth must then stall
      if (i < 3) begin
        r.ar.id = 4'd2;
        r.sel   = 2'd1;
      end else if (i == 3) begin
        r.ar.id = 4'd5;
        r.sel   = 2'd0;
      end
      stim_q.push_back(r);
    end
  endtask

  // --------------------------------------------------------------------------
  // target models driven 10 ns after the edge
  // --------------------------------------------------------------------------
  task automatic drive_port(int unsigned p);
    int idx;
    idx               = find_port_head(p);
    port_r_valid_i[p] = (idx >= 0);
    port_r_i[p]       = '0;
    if (idx >= 0) begin
      port_r_i[p].id   = pend_q[idx].ar.id;
      port_r_i[p].data = expected_data(p, pend_q[idx].ar.addr, port_beat[p]);
      port_r_i[p].last = (port_beat[p] == pend_q[idx].ar.len);
    end
  endtask

  always @(posedge clk_i) begin
    #10;
    port_ar_ready_i = NumPorts'(rand_bits(NumPorts));
    r_ready_i       = !hold_r && (rand_bits(1) != 0);
    for (int unsigned p = 0; p < NumPorts; p++) begin
      drive_port(p);
    end
  end

  // --------------------------------------------------------------------------
  // comparison at the falling edge where all signals are stable
  // --------------------------------------------------------------------------
  task automatic check_ar();
    int unsigned         p;
    logic [NumPorts-1:0] exp_valid;
    logic                exp_ready;
    req_t                acc;
    p         = ar_sel_i;
    exp_valid = '0;
    exp_ready = 1'b0;
    // an unanswered offer stays up whatever the ordering rules say now
    if (ar_valid_i && p < NumPorts && (offer_pending || may_forward(ar_i.id, ar_sel_i))) begin
      exp_valid[p] = 1'b1;
      exp_ready    = port_ar_ready_i[p];
    end
    assert (port_ar_valid_o == exp_valid) else abort_run($sformatf(
      "error at %0t: port_ar_valid_o is %b, expected %b", $time, port_ar_valid_o, exp_valid));
    assert (ar_ready_o == exp_ready) else abort_run($sformatf(
      "error at %0t: ar_ready_o is %b, expected %b", $time, ar_ready_o, exp_ready));
    if (exp_valid != '0) begin
      assert (port_ar_o == ar_i) else abort_run($sformatf(
        "error at %0t: port_ar_o is %h, expected %h", $time, port_ar_o, ar_i));
    end
    if (ar_valid_i && ar_ready_o) begin
      acc.sel = ar_sel_i;
      acc.ar  = ar_i;
      issued_q.push_back(acc);
      pend_q.push_back(acc);
    end
    // the router keeps an unanswered offer up on its own
    offer_pending = (exp_valid != '0) && !exp_ready;
  endtask

  task automatic check_r();
    rd_demux_pkg::data_t exp_data;
    logic [NumPorts-1:0] exp_ready;
    exp_ready = '0;
    // the models hold a burst valid to its end so any valid port means data on offer
    assert (r_valid_o == |port_r_valid_i) else abort_run($sformatf(
      "error at %0t: r_valid_o is %b, expected %b", $time, r_valid_o, |port_r_valid_i));
    if (r_valid_o && r_ready_i) begin
      if (!burst_active) begin
        // oldest open read with this id owns the new burst
        cur_idx = -1;
        foreach (issued_q[i]) begin
          if (cur_idx < 0 && issued_q[i].ar.id == r_o.id) cur_idx = i;
        end
        assert (cur_idx >= 0) else abort_run($sformatf(
          "read data with id %0d at %0t matches no open request", r_o.id, $time));
        cur_req      = issued_q[cur_idx];
        cur_beat     = 0;
        burst_active = 1'b1;
      end
      exp_ready[cur_req.sel] = 1'b1;
      exp_data = expected_data(cur_req.sel, cur_req.ar.addr, cur_beat);
      assert (r_o.id == cur_req.ar.id) else abort_run($sformatf(
        "error at %0t: r_o.id is %0d, expected %0d", $time, r_o.id, cur_req.ar.id));
      assert (r_o.data == exp_data) else abort_run($sformatf(
        "error at %0t: r_o.data is %h, expected %h", $time, r_o.data, exp_data));
      assert (r_o.last == (cur_beat == cur_req.ar.len)) else abort_run($sformatf(
        "error at %0t: r_o.last is %b, expected %b", $time, r_o.last,
        cur_beat == cur_req.ar.len));
      if (r_o.last) begin
        issued_q.delete(cur_idx);
        burst_active = 1'b0;
      end else begin
        cur_beat++;
      end
    end
    // only the port that owns the burst on r_o sees the ready
    assert (port_r_ready_o == exp_ready) else abort_run($sformatf(
      "error at %0t: port_r_ready_o is %b, expected %b", $time, port_r_ready_o, exp_ready));
  endtask

  task automatic update_ports();
    int idx;
    for (int unsigned p = 0; p < NumPorts; p++) begin
      if (port_r_valid_i[p] && port_r_ready_o[p]) begin
        idx = find_port_head(p);
        if (port_beat[p] == pend_q[idx].ar.len) begin
          pend_q.delete(idx);
          port_beat[p] = 0;
        end else begin
          port_beat[p]++;
        end
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i) begin
      check_ar();
      check_r();
      update_ports();
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      abort_run("timeout, the bursts did not all return in time");
    end
  end

  // --------------------------------------------------------------------------
  // requester
  // --------------------------------------------------------------------------
  task automatic drive_request(req_t r);
    @(posedge clk_i);
    #10;
    ar_i       = r.ar;
    ar_sel_i   = r.sel;
    ar_valid_i = 1'b1;
  endtask

  // ready seen mid-cycle means the transfer happens at the next edge
  task automatic wait_transfer();
    do @(negedge clk_i); while (!ar_ready_o);
  endtask

  task automatic send_request(req_t r);
    drive_request(r);
    wait_transfer();
  endtask

  initial begin
    int unsigned total_beats;
    lfsr_q          = 16'd38767;
    rst_n_i         = 1'b0;
    ar_i            = '0;
    ar_sel_i        = '0;
    ar_valid_i      = 1'b0;
    port_ar_ready_i = '0;
    port_r_i        = '0;
    port_r_valid_i  = '0;
    r_ready_i       = 1'b0;
    hold_r          = 1'b1;
    offer_pending   = 1'b0;
    burst_active    = 1'b0;
    cur_idx         = 0;
    cur_beat        = 0;
    cycle_cnt       = 0;
    foreach (port_beat[p]) port_beat[p] = 0;
    build_stimulus();
    total_beats = 0;
    foreach (stim_q[i]) total_beats += stim_q[i].ar.len + 1;
    cycle_limit = 20 * total_beats + 200;

    repeat (5) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    // quiet outputs before the first request
    repeat (3) begin
      @(negedge clk_i);
      assert (!ar_ready_o && !r_valid_o && port_ar_valid_o == '0) else abort_run($sformatf(
        "error at %0t: ar_ready_o, r_valid_o, port_ar_valid_o are %b %b %b, expected 0 0 000",
        $time, ar_ready_o, r_valid_o, port_ar_valid_o));
    end

    // three reads of one id fill its counter while the data is held back
    for (int i = 0; i < 3; i++) send_request(stim_q[i]);
    drive_request(stim_q[3]);
    repeat (6) begin
      @(negedge clk_i);
      assert (port_ar_valid_o == '0) else abort_run($sformatf(
        "error at %0t: port_ar_valid_o is %b, expected 000 while full",
        $time, port_ar_valid_o));
    end
    hold_r = 1'b0;
    wait_transfer();

    for (int i = 4; i < stim_q.size(); i++) send_request(stim_q[i]);
    @(posedge clk_i);
    #10;
    ar_valid_i = 1'b0;
    while (issued_q.size() != 0 || pend_q.size() != 0) @(posedge clk_i);
    $display("All checks passed");
    $finish;
  end

endmodule

// File: sources.f
hdl/rd_demux_pkg.sv
hdl/rd_id_tracker.sv
hdl/ar_router.sv
hdl/r_arbiter.sv
hdl/rd_demux_top.sv
sim/tb_rd_demux.sv

// File: Bender.yml
package:
  name: rd_demux

sources:
  # package first, then the blocks, then the top level
  - files:
      - hdl/rd_demux_pkg.sv
      - hdl/rd_id_tracker.sv
      - hdl/ar_router.sv
      - hdl/r_arbiter.sv
      - hdl/rd_demux_top.sv

  # testbench, top module tb_rd_demux
  - target: simulation
    files:
      - sim/tb_rd_demux.sv
